// ==== all.f ====
+incdir+source
source/sccbCfgPkg.sv
source/cfgSequencer.sv
source/ov7670RegTable.sv
source/sccbWriter.sv
source/cameraConfigTop.sv
testbench/clockGen.sv
testbench/cameraConfigTb.sv

// ==== Bender.yml ====
package:
  name: camera_config

export_include_dirs:
  - source

sources:
  - files:
      - source/sccbCfgPkg.sv
      - source/cfgSequencer.sv
      - source/ov7670RegTable.sv
      - source/sccbWriter.sv
      - source/cameraConfigTop.sv
  - target: simulation
    files:
      - testbench/clockGen.sv
      - testbench/cameraConfigTb.sv

// ==== testbench/cameraConfigTb.sv ====
// Testbench for the camera config chain; expects the 40-entry table and runs three full passes
`timescale 1ns/10ps
`default_nettype none
`include "sccbCfg_consts.svh"

module cameraConfigTb;

	localparam int TimeoutCycles =
		3 * (`CFG_POWERUP_CYCLES + `CFG_TABLE_SIZE * (116 * `SCCB_QUARTER_CYCLES + 4));
	localparam int IdleCycles = 32; // Quiet time watched after each pass
	localparam int RunCount = 3;

	typedef struct packed
	{
		logic pulseFirst; // Start the pass with a reconfigure
		logic pulseBusy; // Extra reconfigure while busy, must be ignored
		logic [7:0] frames;
	} runRowT;

	logic clk;
	logic rstN;
	logic reconfigure;
	logic sioC;
	logic sioDOut;
	logic sioDOe;
	logic busy;
	logic configDone;
	logic sioD; // Line level with the pull-up

	// Expected address and value pairs, in write order
	logic [15:0] expectedRegs [0:`CFG_TABLE_SIZE-1] = '{
		16'h3a04, 16'h40d0, 16'h1204, 16'h32b6, 16'h1713,
		16'h1801, 16'h1902, 16'h1a7a, 16'h030a, 16'h0c00,
		16'h3e00, 16'h7000, 16'h7100, 16'h7211, 16'h7300,
		16'ha202, 16'h1180, 16'h7a20, 16'h7b1c, 16'h7c28,
		16'h7d3c, 16'h7e55, 16'h7f68, 16'h8076, 16'h8180,
		16'h8288, 16'h838f, 16'h8496, 16'h85a3, 16'h86af,
		16'h87c4, 16'h88d7, 16'h89e8, 16'h4f80, 16'h5080,
		16'h5100, 16'h5222, 16'h535e, 16'h5480, 16'h589e
	};

	runRowT runList [0:RunCount-1] = '{
		{1'b0, 1'b1, 8'd40}, // Pass after reset
		{1'b1, 1'b0, 8'd40},
		{1'b1, 1'b1, 8'd40}
	};

	logic [31:0] lfsrState = 32'h068a0b7f;
	int valueErrors = 0;
	int protocolErrors = 0;
	int framesSeen = 0;
	int runBase = 0; // framesSeen at the start of the current pass
	int cycleCount = 0;
	logic prevScl = 1'b1;
	logic prevSda = 1'b1;
	logic inFrame = 1'b0;
	int bitsSeen = 0;
	logic [26:0] shiftBits = '0;

	assign sioD = sioDOe ? sioDOut : 1'b1;

	clockGen clockSource
	(
		.clk(clk)
	);

	cameraConfigTop UUT
	(
		.clk(clk),
		.rstN(rstN),
		.reconfigure(reconfigure),
		.sioC(sioC),
		.sioDOut(sioDOut),
		.sioDOe(sioDOe),
		.busy(busy),
		.configDone(configDone)
	);

	task automatic nextCycle();
		@(posedge clk);
		#1; // Drive and sample clear of the edge
	endtask

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			valueErrors++;
			$display("Fail at %0t ns: %s is 0x%0h, expected 0x%0h",
				$time, name, actual, expected);
		end
	endtask

	task automatic reportProblem(input string what);
		protocolErrors++;
		$display("Error at %0t ns: %s", $time, what);
	endtask

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic takeRandom(input int count, output int value);
		value = 0;
		for (int i = 0; i < count; i++)
		begin
			lfsrState = lfsrNext(lfsrState);
			value = (value << 1) | lfsrState[0]; // One step per bit
		end
	endtask

	task automatic finishFrame();
		int index;
		index = framesSeen - runBase;
		if (bitsSeen != 28) // 27 data bits plus the clock rise of the stop
			reportProblem("stop condition did not follow exactly 27 data bits");
		else if (index >= `CFG_TABLE_SIZE)
			reportProblem("frame beyond the end of the register table");
		else
		begin
			checkValue("deviceId", shiftBits[26:19], `SCCB_DEVICE_ID);
			checkValue("regAddr", shiftBits[17:10], expectedRegs[index][15:8]);
			checkValue("regVal", shiftBits[8:1], expectedRegs[index][7:0]);
		end
		framesSeen++;
	endtask

	// Bus monitor, samples at the falling clock edge where outputs are settled
	always @(negedge clk)
	begin
		if (rstN)
		begin
			if (prevScl && sioC && sioD !== prevSda)
			begin
				if (!sioD)
				begin
					if (inFrame)
						reportProblem("SIOD fell while SIOC high inside a frame");
					inFrame = 1'b1; // Start condition
					bitsSeen = 0;
				end
				else if (inFrame)
				begin
					finishFrame(); // Stop condition
					inFrame = 1'b0;
				end
				else
					reportProblem("SIOD rose while SIOC high outside a frame");
			end
			else if (!prevScl && sioC && inFrame)
			begin
				if (bitsSeen < 27)
				begin
					if (bitsSeen % 9 == 8)
						checkValue("sioDOe", sioDOe, 1'b0); // Ninth bit released
					shiftBits = {shiftBits[25:0], sioD};
				end
				bitsSeen++; // Rise after the last bit leads into the stop
			end
			prevScl = sioC;
			prevSda = sioD;
		end
	end

	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleCount >= TimeoutCycles)
		begin
			$display("Timeout after %0d cycles, the configuration passes did not finish",
				cycleCount);
			$display("Result: FAILED");
			$finish;
		end
	end

	initial
	begin
		int delay;
		int framesAtDone;
		rstN = 1'b0;
		reconfigure = 1'b0;
		repeat (10)
			nextCycle();
		rstN = 1'b1;
		checkValue("sioC", sioC, 1'b1);
		checkValue("sioDOe", sioDOe, 1'b0);
		checkValue("configDone", configDone, 1'b0);
		checkValue("busy", busy, 1'b1);
		for (int run = 0; run < RunCount; run++)
		begin
			if (runList[run].pulseFirst)
			begin
				takeRandom(4, delay);
				repeat (delay)
					nextCycle();
				runBase = framesSeen;
				reconfigure = 1'b1;
				nextCycle();
				reconfigure = 1'b0;
				checkValue("configDone", configDone, 1'b0);
				checkValue("busy", busy, 1'b1);
			end
			if (runList[run].pulseBusy)
			begin
				takeRandom(10, delay);
				repeat (300 + delay) // Lands somewhere in the frames
					nextCycle();
				checkValue("busy", busy, 1'b1);
				reconfigure = 1'b1;
				nextCycle();
				reconfigure = 1'b0;
			end
			while (configDone !== 1'b1)
				nextCycle();
			checkValue("busy", busy, 1'b0);
			checkValue("frameCount", framesSeen - runBase, runList[run].frames);
			framesAtDone = framesSeen;
			for (int i = 0; i < IdleCycles; i++)
			begin
				nextCycle();
				checkValue("sioDOe", sioDOe, 1'b0); // Bus left released while idle
				checkValue("sioC", sioC, 1'b1);
			end
			checkValue("idleFrames", framesSeen, framesAtDone); // Nothing sent while idle
			checkValue("configDone", configDone, 1'b1);
		end
		$display("Errors: %0d value, %0d protocol; frames seen %0d",
			valueErrors, protocolErrors, framesSeen);
		if (valueErrors + protocolErrors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/clockGen.sv ====
// Free-running simulation clock with a 10 ns period, starts low at time zero
`timescale 1ns/10ps
`default_nettype none

module clockGen
(
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk; // Half period
	end

endmodule

`default_nettype wire

// ==== source/cameraConfigTop.sv ====
// Camera config top; sioDOut and sioDOe must be combined into an open-drain pad with a pull-up outside this block
`timescale 1ns/10ps
`default_nettype none

module cameraConfigTop
(
	input wire logic clk,
	input wire logic rstN,
	input wire logic reconfigure,
	output logic sioC,
	output logic sioDOut,
	output logic sioDOe,
	output logic busy,
	output logic configDone
);

	import sccbCfgPkg::*;

	logic fetch;
	tableIndexT fetchIndex;
	cfgEntryT entry;
	logic entryValid;
	logic writeDone; // Back to the sequencer

	cfgSequencer sequencer
	(
		.clk(clk),
		.rstN(rstN),
		.reconfigure(reconfigure),
		.writeDone(writeDone),
		.fetch(fetch),
		.fetchIndex(fetchIndex),
		.busy(busy),
		.configDone(configDone)
	);

	ov7670RegTable regTable
	(
		.clk(clk),
		.rstN(rstN),
		.fetch(fetch),
		.fetchIndex(fetchIndex),
		.entry(entry),
		.entryValid(entryValid)
	);

	sccbWriter writer
	(
		.clk(clk),
		.rstN(rstN),
		.entry(entry),
		.entryValid(entryValid),
		.sioC(sioC),
		.sioDOut(sioDOut),
		.sioDOe(sioDOe),
		.writeDone(writeDone)
	);

endmodule

`default_nettype wire

// ==== source/sccbWriter.sv ====
// SCCB three-phase write only; no reads, the ninth bit is released and never checked, no clock stretching
`timescale 1ns/10ps
`default_nettype none
`include "sccbCfg_consts.svh"

module sccbWriter
(
	input wire logic clk,
	input wire logic rstN,
	input wire sccbCfgPkg::cfgEntryT entry,
	input wire logic entryValid,
	output logic sioC,
	output logic sioDOut,
	output logic sioDOe,
	output logic writeDone
);

	import sccbCfgPkg::*;

	localparam int QuarterWidth = $clog2(`SCCB_QUARTER_CYCLES);
	localparam int FrameBits = 27;
	localparam int LastBit = FrameBits - 1;

	wrStateE state;
	logic [QuarterWidth-1:0] quarterCount; // Cycles inside one quarter bit
	logic [1:0] phase; // Quarter inside the current bit time
	logic [4:0] bitCount;
	logic [3:0] slot; // Bit position inside a byte, 8 is the released bit
	logic [FrameBits-1:0] frame; // MSB goes out first
	logic tick;

	assign tick = (quarterCount == QuarterWidth'(`SCCB_QUARTER_CYCLES - 1));

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			state <= wIdle;
			quarterCount <= '0;
			phase <= '0;
			bitCount <= '0;
			slot <= '0;
		end
		else if (state == wIdle)
		begin
			quarterCount <= '0;
			phase <= '0;
			if (entryValid)
				state <= wStart;
		end
		else if (!tick)
			quarterCount <= quarterCount + 1'b1;
		else
		begin
			quarterCount <= '0;
			phase <= phase + 1'b1;
			if (phase == 2'd3)
			begin
				case (state)
					wStart:
					begin
						state <= wBits;
						bitCount <= '0;
						slot <= '0;
					end
					wBits:
					begin
						if (bitCount == 5'(LastBit))
							state <= wStop;
						else
							bitCount <= bitCount + 1'b1;
						slot <= (slot == 4'd8) ? 4'd0 : slot + 1'b1;
					end
					default:
						state <= wIdle; // End of stop bit
				endcase
			end
		end
	end

	// Payload shifter, each byte padded with a high don't-care bit
	always_ff @(posedge clk)
	begin
		if (state == wIdle && entryValid)
			frame <= {`SCCB_DEVICE_ID, 1'b1, entry.addr, 1'b1, entry.val, 1'b1};
		else if (state == wBits && tick && phase == 2'd3)
			frame <= {frame[LastBit-1:0], 1'b0};
	end

	always_comb
	begin
		sioC = 1'b1;
		sioDOut = 1'b1;
		sioDOe = 1'b0;
		case (state)
			wStart:
			begin
				sioDOe = 1'b1;
				sioDOut = (phase == 2'd0); // Falls while SIOC high
				sioC = (phase != 2'd3);
			end
			wBits:
			begin
				sioDOe = (slot != 4'd8); // Release for the ninth bit
				sioDOut = frame[LastBit];
				sioC = (phase == 2'd1) || (phase == 2'd2);
			end
			wStop:
			begin
				sioDOe = 1'b1;
				sioDOut = (phase >= 2'd2); // Rises while SIOC high
				sioC = (phase != 2'd0);
			end
			default:
				sioC = 1'b1;
		endcase
	end

	assign writeDone = (state == wStop) && (phase == 2'd3) && tick; // Last cycle of the frame

endmodule

`default_nettype wire

// ==== source/ov7670RegTable.sv ====
// OV7670 register table cut to 40 entries for RGB565 VGA; indices past the last entry return address and value zero
`timescale 1ns/10ps
`default_nettype none

module ov7670RegTable
(
	input wire logic clk,
	input wire logic rstN,
	input wire logic fetch,
	input wire sccbCfgPkg::tableIndexT fetchIndex,
	output sccbCfgPkg::cfgEntryT entry,
	output logic entryValid
);

	import sccbCfgPkg::*;

	cfgEntryT lookup; // Selected address and value pair

	always_comb
	begin
		case (fetchIndex)
			6'd0: lookup = {8'h3a, 8'h04}; // Output sequence
			6'd1: lookup = {8'h40, 8'hd0}; // RGB565, full range
			6'd2: lookup = {8'h12, 8'h04}; // VGA with RGB output
			6'd3: lookup = {8'h32, 8'hb6}; // HREF control
			6'd4: lookup = {8'h17, 8'h13}; // HSTART
			6'd5: lookup = {8'h18, 8'h01}; // HSTOP
			6'd6: lookup = {8'h19, 8'h02}; // VSTART
			6'd7: lookup = {8'h1a, 8'h7a}; // VSTOP
			6'd8: lookup = {8'h03, 8'h0a}; // VREF low bits
			6'd9: lookup = {8'h0c, 8'h00}; // No downsampling
			6'd10: lookup = {8'h3e, 8'h00}; // PCLK not divided
			6'd11: lookup = {8'h70, 8'h00};
			6'd12: lookup = {8'h71, 8'h00};
			6'd13: lookup = {8'h72, 8'h11}; // Scaling default
			6'd14: lookup = {8'h73, 8'h00}; // DSP clock not divided
			6'd15: lookup = {8'ha2, 8'h02}; // Pixel clock delay
			6'd16: lookup = {8'h11, 8'h80}; // External clock direct
			// Gamma curve, slope then 15 points
			6'd17: lookup = {8'h7a, 8'h20};
			6'd18: lookup = {8'h7b, 8'h1c};
			6'd19: lookup = {8'h7c, 8'h28};
			6'd20: lookup = {8'h7d, 8'h3c};
			6'd21: lookup = {8'h7e, 8'h55};
			6'd22: lookup = {8'h7f, 8'h68};
			6'd23: lookup = {8'h80, 8'h76};
			6'd24: lookup = {8'h81, 8'h80};
			6'd25: lookup = {8'h82, 8'h88};
			6'd26: lookup = {8'h83, 8'h8f};
			6'd27: lookup = {8'h84, 8'h96};
			6'd28: lookup = {8'h85, 8'ha3};
			6'd29: lookup = {8'h86, 8'haf};
			6'd30: lookup = {8'h87, 8'hc4};
			6'd31: lookup = {8'h88, 8'hd7};
			6'd32: lookup = {8'h89, 8'he8};
			// Colour matrix coefficients and sign
			6'd33: lookup = {8'h4f, 8'h80};
			6'd34: lookup = {8'h50, 8'h80};
			6'd35: lookup = {8'h51, 8'h00};
			6'd36: lookup = {8'h52, 8'h22};
			6'd37: lookup = {8'h53, 8'h5e};
			6'd38: lookup = {8'h54, 8'h80};
			6'd39: lookup = {8'h58, 8'h9e}; // Matrix sign bits
			default: lookup = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
			entryValid <= 1'b0;
		else
			entryValid <= fetch; // Fixed one-cycle latency
	end

	always_ff @(posedge clk)
	begin
		if (fetch)
			entry <= lookup;
	end

endmodule

`default_nettype wire

// ==== source/cfgSequencer.sv ====
// Walks the register table once after the power-up wait; reconfigure is only accepted after the pass is done
`timescale 1ns/10ps
`default_nettype none
`include "sccbCfg_consts.svh"

module cfgSequencer
(
	input wire logic clk,
	input wire logic rstN,
	input wire logic reconfigure,
	input wire logic writeDone,
	output logic fetch,
	output sccbCfgPkg::tableIndexT fetchIndex,
	output logic busy,
	output logic configDone
);

	import sccbCfgPkg::*;

	localparam int WaitWidth = $clog2(`CFG_POWERUP_CYCLES + 1);
	localparam int LastIndex = `CFG_TABLE_SIZE - 1;

	seqStateE state;
	logic [WaitWidth-1:0] waitCount; // Cycles left before the first fetch

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			state <= sWait;
			waitCount <= WaitWidth'(`CFG_POWERUP_CYCLES - 1);
			fetchIndex <= '0;
		end
		else
		begin
			case (state)
				sWait:
				begin
					if (waitCount == '0)
						state <= sFetch; // Wait over, first entry
					else
						waitCount <= waitCount - 1'b1;
				end
				sFetch:
					state <= sWrite; // Table and writer take it from here
				sWrite:
				begin
					if (writeDone)
					begin
						if (fetchIndex == tableIndexT'(LastIndex))
							state <= sDone;
						else
						begin
							fetchIndex <= fetchIndex + 1'b1;
							state <= sFetch;
						end
					end
				end
				sDone:
				begin
					// Restart the whole pass, including the sensor settle time
					if (reconfigure)
					begin
						state <= sWait;
						waitCount <= WaitWidth'(`CFG_POWERUP_CYCLES - 1);
						fetchIndex <= '0;
					end
				end
				default:
					state <= sWait;
			endcase
		end
	end

	assign fetch = (state == sFetch); // One cycle per entry
	assign busy = (state != sDone);
	assign configDone = (state == sDone); // Drops the cycle after reconfigure

endmodule

`default_nettype wire

// ==== source/sccbCfgPkg.sv ====
// Shared types of the camera config chain; the table index is fixed at 6 bits, which limits the table to 64 entries
`default_nettype none

package sccbCfgPkg;

	typedef logic [7:0] regAddrT; // Sensor register address
	typedef logic [7:0] regValT; // Register value
	typedef logic [5:0] tableIndexT; // Index into the register table

	typedef struct packed
	{
		regAddrT addr;
		regValT val;
	} cfgEntryT;

	typedef enum logic [1:0]
	{
		sWait, // Power-up delay
		sFetch, // Fetch strobe to the table
		sWrite, // Waiting on the writer
		sDone // Table finished
	} seqStateE;

	typedef enum logic [1:0]
	{
		wIdle,
		wStart,
		wBits,
		wStop
	} wrStateE;

endpackage

`default_nettype wire

// ==== source/sccbCfg_consts.svh ====
// Build constants for the SCCB config chain; table size must fit a 6-bit index and quarter period must be at least 2
`ifndef SCCB_CFG_CONSTS_SVH
`define SCCB_CFG_CONSTS_SVH

// OV7670 write address on the SCCB bus
`define SCCB_DEVICE_ID 8'h42

// Number of register writes in one configuration pass
`define CFG_TABLE_SIZE 40

// Clock cycles from reset release or reconfigure to the first fetch
`define CFG_POWERUP_CYCLES 200

// Clock cycles per quarter SCCB bit, so one bit lasts four of these
`define SCCB_QUARTER_CYCLES 4

`endif
